// File: Bender.yml
package:
  name: output_layer_block

sources:
  # Package first, then leaf modules, then the top level
  - files:
      - rtl/ol_pkg.sv
      - rtl/answer_delay_line.sv
      - rtl/delta_sequencer.sv
      - rtl/delta_pingpong_mem.sv
      - rtl/act_argmax.sv
      - rtl/output_layer_block.sv

  # Testbench, top module tb_output_layer
  - target: simulation
    files:
      - verif/tb_clk_gen.sv
      - verif/tb_output_layer.sv

// File: rtl/act_argmax.sv
// Signed compare over slots 0..P_OUT-1 of each junction; ties keep the lowest neuron index
`timescale 1ns/1ps
`default_nettype none

module act_argmax (
	input  logic                      clk,
	input  logic                      rst_n_i,
	input  logic [ol_pkg::IDX_W-1:0]  cycle_index_i,
	input  ol_pkg::fx_t               act_i,
	output logic [ol_pkg::CIDX_W-1:0] class_o,       // Index of the largest activation
	output logic                      class_valid_o  // One-clock pulse in slot P_OUT
);

	ol_pkg::fx_t               max_q;    // Running maximum, loaded fresh in slot 0
	logic [ol_pkg::CIDX_W-1:0] idx_q;    // Neuron holding max_q
	logic                      slot_first;
	logic                      slot_act;
	logic                      slot_end; // Last neuron of the junction
	logic                      take;     // Current activation becomes the new maximum
	logic [ol_pkg::CIDX_W-1:0] idx_cur;

	assign slot_first = (cycle_index_i == ol_pkg::SLOT_FIRST);
	assign slot_act   = (cycle_index_i < ol_pkg::SLOT_NUM_ACT);
	assign slot_end   = (cycle_index_i == ol_pkg::SLOT_LAST_ACT);
	assign idx_cur    = cycle_index_i[ol_pkg::CIDX_W-1:0];

	// Strictly greater, so an equal later value loses
	assign take = slot_first | (slot_act & (act_i > max_q));

	// Running maximum value, data only
	always_ff @(posedge clk) begin
		if (take) begin
			max_q <= act_i;
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			idx_q         <= '0;
			class_o       <= '0;
			class_valid_o <= 1'b0;
		end else begin
			if (take) begin
				idx_q <= idx_cur;
			end
			class_valid_o <= slot_end; // High during the first idle slot
			if (slot_end) begin
				// Final neuron may still win, so look past idx_q
				class_o <= take ? idx_cur : idx_q;
			end
		end
	end

endmodule

`default_nettype wire

// File: rtl/answer_delay_line.sv
// One-bit answers only, fixed delay of ANS_DELAY clocks, no stall input so it shifts every clock
`timescale 1ns/1ps
`default_nettype none

module answer_delay_line (
	input  logic clk,
	input  logic rst_n_i,
	input  logic ans_i,  // Ideal answer at network entry
	output logic ans_o   // Same answer, ANS_DELAY clocks later
);

	// Stage 0 is the newest bit
	logic [ol_pkg::ANS_DELAY-1:0] stage_q;

	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			stage_q <= '0; // Line reads as "answer 0" until filled
		end else begin
			stage_q <= {stage_q[ol_pkg::ANS_DELAY-2:0], ans_i}; // One stage per clock
		end
	end

	// Oldest stage leaves the line
	assign ans_o = stage_q[ol_pkg::ANS_DELAY-1];

endmodule

`default_nettype wire

// File: rtl/delta_pingpong_mem.sv
// Two P_OUT-deep banks, one write and one registered read per clock, bank contents unknown after reset
`timescale 1ns/1ps
`default_nettype none

module delta_pingpong_mem (
	input  logic            clk,
	input  logic            rst_n_i,
	input  ol_pkg::del_wr_t wr_i,  // Write request from the sequencer
	input  ol_pkg::del_rd_t rd_i,  // Read request from the sequencer
	output ol_pkg::fx_t     del_o  // Delta to the previous layer, one clock after the request
);

	ol_pkg::fx_t bank0_q [ol_pkg::P_OUT]; // Even junctions after reset
	ol_pkg::fx_t bank1_q [ol_pkg::P_OUT]; // Odd junctions after reset
	ol_pkg::fx_t rd_data;                 // Read mux output
	ol_pkg::fx_t rd_q;
	logic        we0;
	logic        we1;

	// Bank select on the write side
	assign we0 = wr_i.we & ~wr_i.bank;
	assign we1 = wr_i.we &  wr_i.bank;

	always_ff @(posedge clk) begin
		if (we0) begin
			bank0_q[wr_i.addr] <= wr_i.data;
		end
		if (we1) begin
			bank1_q[wr_i.addr] <= wr_i.data;
		end
	end

	// Read mux picks bank then word
	always_comb begin
		if (rd_i.bank) begin
			rd_data = bank1_q[rd_i.addr];
		end else begin
			rd_data = bank0_q[rd_i.addr];
		end
	end

	// Registered read port
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			rd_q <= '0; // Previous layer sees zero deltas until the first swap
		end else begin
			rd_q <= rd_data;
		end
	end

	assign del_o = rd_q;

endmodule

`default_nettype wire

// File: rtl/delta_sequencer.sv
// Expects cycle_index_i to count 0..CPC-1 and wrap every clock; cross-entropy delta only, no saturation
`timescale 1ns/1ps
`default_nettype none

module delta_sequencer (
	input  logic                     clk,
	input  logic                     rst_n_i,
	input  logic [ol_pkg::IDX_W-1:0] cycle_index_i, // Slot inside the junction cycle
	input  ol_pkg::fx_t              act_i,         // Activation of neuron cycle_index_i
	input  logic                     ans_dly_i,     // Ideal answer, delayed to match act_i
	output ol_pkg::del_wr_t          wr_o,          // Write into the filling bank
	output ol_pkg::del_rd_t          rd_o           // Read from the draining bank
);

	logic        wr_ptr_q;   // Bank receiving deltas this junction
	logic        slot_act;   // Neuron slot, not one of the two idle slots
	logic        slot_last;  // Final clock of the junction
	ol_pkg::fx_t ans_fx;     // Ideal answer widened to a fixed-point word
	ol_pkg::fx_t delta;

	// Slot decode
	assign slot_act  = (cycle_index_i < ol_pkg::SLOT_NUM_ACT);
	assign slot_last = (cycle_index_i == ol_pkg::SLOT_LAST);

	// Ping-pong pointer, flips on the junction boundary
	always_ff @(posedge clk) begin
		if (!rst_n_i) begin
			wr_ptr_q <= 1'b0;
		end else if (slot_last) begin
			wr_ptr_q <= ~wr_ptr_q;
		end
	end

	// Answer bit is 0 or 1.0 in fixed point
	assign ans_fx = ans_dly_i ? ol_pkg::FX_ONE : '0;

	// Cross-entropy with sigmoid output gives a plain difference, wraps on overflow
	assign delta = act_i - ans_fx;

	always_comb begin
		wr_o.we   = slot_act;                            // No writes in idle slots
		wr_o.bank = wr_ptr_q;
		wr_o.addr = cycle_index_i[ol_pkg::ADDR_W-1:0];   // Neuron k goes to address k
		wr_o.data = delta;
	end

	// Read side walks the other bank at the same pace
	// Idle slots read harmless aliased addresses, nobody samples them
	always_comb begin
		rd_o.bank = ~wr_ptr_q;
		rd_o.addr = cycle_index_i[ol_pkg::ADDR_W-1:0];
	end

endmodule

`default_nettype wire

// File: rtl/ol_pkg.sv
// Sizes fixed here for 4 output neurons, 1 neuron per clock, 3 layers, Q5.10 words with wraparound
`default_nettype none

package ol_pkg;

	// Fixed-point format, sign + integer + fraction
	localparam int INT_BITS  = 5;
	localparam int FRAC_BITS = 10; // Weight of 1.0 is 2**FRAC_BITS
	localparam int WIDTH     = 1 + INT_BITS + FRAC_BITS;

	// Network geometry
	localparam int P_OUT      = 4;         // Output neurons, one per clock
	localparam int CPC        = P_OUT + 2; // Clocks per junction cycle
	localparam int NUM_LAYERS = 3;

	// Ideal answers enter at the network's entry and wait out every junction in front
	localparam int ANS_DELAY = CPC * (NUM_LAYERS - 1);

	// Index widths
	localparam int IDX_W  = $clog2(CPC);   // Cycle index
	localparam int ADDR_W = $clog2(P_OUT); // Address inside one delta bank
	localparam int CIDX_W = $clog2(P_OUT); // Predicted class

	// Slot markers inside a junction cycle
	localparam logic [IDX_W-1:0] SLOT_FIRST    = '0;
	localparam logic [IDX_W-1:0] SLOT_LAST_ACT = IDX_W'(P_OUT - 1); // Last neuron slot
	localparam logic [IDX_W-1:0] SLOT_NUM_ACT  = IDX_W'(P_OUT);     // First idle slot
	localparam logic [IDX_W-1:0] SLOT_LAST     = IDX_W'(CPC - 1);   // Junction boundary

	// Signed fixed-point word
	typedef logic signed [WIDTH-1:0] fx_t;

	localparam fx_t FX_ONE = fx_t'(1 << FRAC_BITS); // 1.0, the "on" answer

	// Delta write request, sequencer to memory
	typedef struct packed {
		logic              we;   // High in active slots only
		logic              bank; // Bank being filled this junction
		logic [ADDR_W-1:0] addr; // Neuron number
		fx_t               data; // Activation minus ideal answer
	} del_wr_t;

	// Delta read request, sequencer to memory
	typedef struct packed {
		logic              bank; // Always the bank not being written
		logic [ADDR_W-1:0] addr;
	} del_rd_t;

endpackage

`default_nettype wire

// File: rtl/output_layer_block.sv
// Output layer only, cross-entropy cost, cycle_index_i must count 0..CPC-1 continuously, no back-pressure
`timescale 1ns/1ps
`default_nettype none

module output_layer_block (
	input  logic                      clk,
	input  logic                      rst_n_i,
	input  logic [ol_pkg::IDX_W-1:0]  cycle_index_i, // Slot inside the junction cycle
	input  ol_pkg::fx_t               act_i,         // One output-neuron activation per active slot
	input  logic                      ans_i,         // Ideal answer at network entry
	output ol_pkg::fx_t               del_o,         // Deltas of the previous junction, to previous layer
	output logic                      ans_o,         // Ideal answer after the network depth
	output logic [ol_pkg::CIDX_W-1:0] class_o,       // Predicted class
	output logic                      class_valid_o
);

	logic            ans_dly;
	ol_pkg::del_wr_t del_wr;
	ol_pkg::del_rd_t del_rd;

	// Answers catch up with the activations they belong to
	answer_delay_line u_ans_dly (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.ans_i   (ans_i),
		.ans_o   (ans_dly)
	);

	assign ans_o = ans_dly; // Also handed out for cost monitoring

	// Delta and bank addressing
	delta_sequencer u_seq (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.cycle_index_i (cycle_index_i),
		.act_i         (act_i),
		.ans_dly_i     (ans_dly),
		.wr_o          (del_wr),
		.rd_o          (del_rd)
	);

	// Ping-pong storage
	delta_pingpong_mem u_mem (
		.clk     (clk),
		.rst_n_i (rst_n_i),
		.wr_i    (del_wr),
		.rd_i    (del_rd),
		.del_o   (del_o)
	);

	// Predicted class runs beside the delta path
	act_argmax u_argmax (
		.clk           (clk),
		.rst_n_i       (rst_n_i),
		.cycle_index_i (cycle_index_i),
		.act_i         (act_i),
		.class_o       (class_o),
		.class_valid_o (class_valid_o)
	);

endmodule

`default_nettype wire

// File: sources.f
rtl/ol_pkg.sv
rtl/answer_delay_line.sv
rtl/delta_sequencer.sv
rtl/delta_pingpong_mem.sv
rtl/act_argmax.sv
rtl/output_layer_block.sv
verif/tb_clk_gen.sv
verif/tb_output_layer.sv

// File: verif/tb_clk_gen.sv
// Free-running 100 ns clock from time 0, reset low for 3 rising edges then released on a falling edge
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
	output logic clk_o,
	output logic rst_n_o
);

	localparam int HALF_NS    = 50; // Half of the 100 ns period
	localparam int RST_CYCLES = 3;

	initial begin
		clk_o = 1'b0;
		forever #HALF_NS clk_o = ~clk_o;
	end

	// Synchronous reset seen by 3 rising edges
	initial begin
		rst_n_o = 1'b0;
		repeat (RST_CYCLES) @(posedge clk_o);
		@(negedge clk_o); // Release away from the sampling edge
		rst_n_o = 1'b1;
	end

endmodule

`default_nettype wire

// File: verif/tb_output_layer.sv
// Drives cycle_index_i itself from the first clock after reset; 40 random junction cycles, no file I/O
`timescale 1ns/1ps
`default_nettype none

module tb_output_layer;

	localparam int N_JUNC      = 40;
	localparam int CPC         = ol_pkg::CPC;
	localparam int P_OUT       = ol_pkg::P_OUT;
	localparam int N_STEPS     = N_JUNC * CPC;
	localparam int ANS_DELAY   = 12;                              // Answer delay in clocks
	localparam int CLK_NS      = 100;
	localparam int WATCHDOG_NS = 2 * N_JUNC * CPC * CLK_NS;
	localparam int ACT_MAX     = 1 << ol_pkg::FRAC_BITS;         // 1.0 in fixed point
	localparam int unsigned SEED = 32'h343ec456;

	// Test numbers
	localparam int N_TESTS = 5;
	localparam int T_RESET = 0;
	localparam int T_ANS   = 1;
	localparam int T_DELTA = 2;
	localparam int T_PING  = 3;
	localparam int T_CLASS = 4;

	logic                      clk;
	logic                      rst_n;
	logic [ol_pkg::IDX_W-1:0]  cycle_index;
	ol_pkg::fx_t               act;
	logic                      ans;
	ol_pkg::fx_t               del;
	logic                      ans_dly;
	logic [ol_pkg::CIDX_W-1:0] class_idx;
	logic                      class_valid;

	// Stimulus history indexed by step after reset
	ol_pkg::fx_t act_hist [N_STEPS];
	logic        ans_hist [N_STEPS];
	ol_pkg::fx_t junc_max;    // Largest activation so far in the junction being driven
	int          drv_count;   // Steps driven so far
	bit          checks_done;
	int          chk_cnt [N_TESTS];
	int          err_cnt [N_TESTS];
	int          ties_forced;

	tb_clk_gen u_clk (
		.clk_o   (clk),
		.rst_n_o (rst_n)
	);

	output_layer_block dut0 (
		.clk           (clk),
		.rst_n_i       (rst_n),
		.cycle_index_i (cycle_index),
		.act_i         (act),
		.ans_i         (ans),
		.del_o         (del),
		.ans_o         (ans_dly),
		.class_o       (class_idx),
		.class_valid_o (class_valid)
	);

	function automatic string test_name(input int id);
		case (id)
			T_RESET: test_name = "reset state";
			T_ANS:   test_name = "answer delay";
			T_DELTA: test_name = "delta values";
			T_PING:  test_name = "ping-pong isolation";
			default: test_name = "predicted class";
		endcase
	endfunction

	// Answer the delta path sees at a step (zero while the line fills)
	function automatic logic delayed_ans(input int step);
		if (step >= ANS_DELAY) begin
			delayed_ans = ans_hist[step - ANS_DELAY];
		end else begin
			delayed_ans = 1'b0;
		end
	endfunction

	// Cross-entropy delta is the activation minus 0 or 1.0 and wraps at WIDTH bits
	function automatic ol_pkg::fx_t ref_delta(input ol_pkg::fx_t a, input logic ideal);
		logic [ol_pkg::WIDTH-1:0] one;
		one = ol_pkg::WIDTH'(ACT_MAX);
		if (ideal) begin
			ref_delta = a - one;
		end else begin
			ref_delta = a;
		end
	endfunction

	// First neuron with the largest signed activation of a junction
	function automatic logic [ol_pkg::CIDX_W-1:0] ref_class(input int junc);
		int base;
		int best;
		int k;
		base = junc * CPC;
		best = 0;
		for (k = 1; k < P_OUT; k++) begin
			if ($signed(act_hist[base + k]) > $signed(act_hist[base + best])) begin
				best = k; // Strictly greater only
			end
		end
		ref_class = ol_pkg::CIDX_W'(best);
	endfunction

	task automatic flag_mismatch(input int id, input string what,
		input logic [ol_pkg::WIDTH-1:0] expv, input logic [ol_pkg::WIDTH-1:0] gotv);
		err_cnt[id]++;
		$display("** Error at %0t ns: %s, expected %h, got %h", $time, what, expv, gotv);
	endtask

	task automatic print_test_line(input int id);
		$display("Test %s finished: %0d checks, %0d errors, %s", test_name(id),
			chk_cnt[id], err_cnt[id], (err_cnt[id] == 0) ? "ok" : "FAIL");
	endtask

	// One step of stimulus applied on the falling edge
	task automatic drive_step(input int t);
		int          k;
		ol_pkg::fx_t a;
		k = t % CPC;
		a = ol_pkg::fx_t'($urandom % (ACT_MAX + 1)); // 0 .. 1.0
		if (k > 0 && k < P_OUT) begin
			if (($urandom % 4) == 0) begin
				a = junc_max; // Tie with the current leader
				ties_forced++;
			end
		end
		if (k == 0) begin
			junc_max = a;
		end else if (k < P_OUT && $signed(a) > $signed(junc_max)) begin
			junc_max = a;
		end
		cycle_index = ol_pkg::IDX_W'(k);
		act         = a;
		ans         = (($urandom % 2) == 1);
		act_hist[t] = a;
		ans_hist[t] = ans;
		drv_count   = t + 1;
	endtask

	// Rising edge t sees the state left by step t-1
	task automatic check_outputs(input int t);
		int                        s;
		int                        k;
		int                        j;
		logic                      exp_ans;
		logic                      exp_valid;
		ol_pkg::fx_t               exp_del;
		ol_pkg::fx_t               cur_del;
		logic [ol_pkg::CIDX_W-1:0] exp_cls;
		if (t == 0) begin
			chk_cnt[T_RESET] += 3;
			if (class_valid !== 1'b0) begin
				flag_mismatch(T_RESET, "class_valid_o after reset", '0, class_valid);
			end
			if (del !== '0) begin
				flag_mismatch(T_RESET, "del_o after reset", '0, del);
			end
			if (ans_dly !== 1'b0) begin
				flag_mismatch(T_RESET, "ans_o after reset", '0, ans_dly);
			end
			print_test_line(T_RESET);
		end else begin
			s = t - 1;
			k = s % CPC;
			j = s / CPC;

			// ans_o is ans_i of 12 clocks back and zero while the line fills
			exp_ans = delayed_ans(t);
			chk_cnt[T_ANS]++;
			if (ans_dly !== exp_ans) begin
				flag_mismatch(T_ANS, $sformatf("ans_o at step %0d", t), exp_ans, ans_dly);
			end

			// Read-out of the previous junction in the active slots
			if (k < P_OUT && j >= 1) begin
				exp_del = ref_delta(act_hist[s - CPC], delayed_ans(s - CPC));
				cur_del = ref_delta(act_hist[s], delayed_ans(s)); // Being written now
				chk_cnt[T_DELTA]++;
				if (del !== exp_del) begin
					flag_mismatch(T_DELTA, $sformatf("del_o junction %0d slot %0d", j, k),
						exp_del, del);
				end
				if (exp_del != cur_del) begin
					chk_cnt[T_PING]++;
					if (del === cur_del) begin
						flag_mismatch(T_PING, $sformatf("del_o shows bank being written, slot %0d",
							k), exp_del, del);
					end
				end
			end

			// Valid pulse only after the last neuron slot
			exp_valid = (k == P_OUT - 1);
			chk_cnt[T_CLASS]++;
			if (class_valid !== exp_valid) begin
				flag_mismatch(T_CLASS, $sformatf("class_valid_o at step %0d", t), exp_valid,
					class_valid);
			end
			if (exp_valid) begin
				exp_cls = ref_class(j);
				chk_cnt[T_CLASS]++;
				if (class_idx !== exp_cls) begin
					flag_mismatch(T_CLASS, $sformatf("class_o junction %0d", j), exp_cls,
						class_idx);
				end
			end
		end
	endtask

	// Comparison process
	always @(posedge clk) begin
		if (drv_count > 0 && !checks_done) begin
			check_outputs(drv_count - 1);
			if (drv_count == N_STEPS) begin
				checks_done = 1'b1;
			end
		end
	end

	// Stimulus and final report
	initial begin
		int unsigned seed_ret;
		int          t;
		int          n_fail;
		int          n_chk;
		int          n_err;
		seed_ret    = $urandom(SEED);
		cycle_index = '0;
		act         = '0;
		ans         = 1'b0;
		junc_max    = '0;
		drv_count   = 0;
		checks_done = 1'b0;
		ties_forced = 0;
		for (t = 0; t < N_TESTS; t++) begin
			chk_cnt[t] = 0;
			err_cnt[t] = 0;
		end

		wait (rst_n === 1'b1); // Released on a falling edge
		for (t = 0; t < N_STEPS; t++) begin
			if (t > 0) begin
				@(negedge clk);
			end
			drive_step(t);
		end
		wait (checks_done);

		n_fail = 0;
		n_chk  = 0;
		n_err  = 0;
		for (t = 0; t < N_TESTS; t++) begin
			if (t != T_RESET) begin
				print_test_line(t);
			end
			if (err_cnt[t] != 0) begin
				n_fail++;
			end
			n_chk += chk_cnt[t];
			n_err += err_cnt[t];
		end
		$display("Summary: %0d tests passed, %0d tests failed, %0d checks, %0d errors, %0d ties",
			N_TESTS - n_fail, n_fail, n_chk, n_err, ties_forced);
		if (n_fail == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	// Watchdog allows twice the nominal run length
	initial begin
		#WATCHDOG_NS;
		$display("Simulation hung: checks not finished after %0d ns", WATCHDOG_NS);
		$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire
